/* src/riscv_isa_pkg.sv */
////////////////////
// RV32I base subset only. No fence, csr or compressed encodings.
////////////////////
package riscv_isa_pkg;

  localparam int xlen = 32;

  typedef enum logic [6:0] {
    op_lui    = 7'b0110111,
    op_auipc  = 7'b0010111,
    op_jal    = 7'b1101111,
    op_jalr   = 7'b1100111,
    op_branch = 7'b1100011,
    op_load   = 7'b0000011,
    op_store  = 7'b0100011,
    op_op_imm = 7'b0010011,
    op_op     = 7'b0110011,
    op_system = 7'b1110011
  } opcode_e;

  // Branch conditions.
  localparam logic [2:0] br_beq  = 3'b000;
  localparam logic [2:0] br_bne  = 3'b001;
  localparam logic [2:0] br_blt  = 3'b100;
  localparam logic [2:0] br_bge  = 3'b101;
  localparam logic [2:0] br_bltu = 3'b110;
  localparam logic [2:0] br_bgeu = 3'b111;

  // Access sizes. Bit 2 marks a zero-extended load.
  localparam logic [2:0] size_byte   = 3'b000;
  localparam logic [2:0] size_half   = 3'b001;
  localparam logic [2:0] size_word   = 3'b010;
  localparam logic [2:0] size_byte_u = 3'b100;
  localparam logic [2:0] size_half_u = 3'b101;

  // ALU functions.
  localparam logic [2:0] alu_add  = 3'b000;
  localparam logic [2:0] alu_sll  = 3'b001;
  localparam logic [2:0] alu_slt  = 3'b010;
  localparam logic [2:0] alu_sltu = 3'b011;
  localparam logic [2:0] alu_xor  = 3'b100;
  localparam logic [2:0] alu_srl  = 3'b101;
  localparam logic [2:0] alu_or   = 3'b110;
  localparam logic [2:0] alu_and  = 3'b111;

  // Selects sub and sra.
  localparam logic [6:0] alt_funct7 = 7'b0100000;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
  } i_type_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
  } s_type_t;

  // Branch offset bits are scattered around the register fields.
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_e    opcode;
  } b_type_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    opcode_e     opcode;
  } u_type_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    opcode_e    opcode;
  } j_type_t;

  typedef union packed {
    r_type_t r;
    i_type_t i;
    s_type_t s;
    b_type_t b;
    u_type_t u;
    j_type_t j;
  } instr_t;

endpackage

/* src/riscv_core_pkg.sv */
////////////////////
// Byte addresses are 16 bits. RAM depth must be a power of two.
////////////////////
package riscv_core_pkg;

  localparam int addr_width = 16;
  localparam int ram_words = 1024;
  localparam int ram_index_width = $clog2(ram_words);

  typedef logic [31:0] word_t;
  typedef logic [addr_width-1:0] addr_t;

  localparam addr_t reset_pc = '0;

  typedef enum logic [3:0] {
    st_reset,
    st_fetch_0,
    st_fetch_1,
    st_decode,
    st_alu_wb,
    st_alu_rr,
    st_branch,
    st_load_wait,
    st_store_0,
    st_store_1,
    st_halted,
    st_error
  } state_e;

endpackage

/* src/data_req_if.sv */
////////////////////
// One-cycle strobes. Read data is valid the cycle after bus_enable.
////////////////////
interface data_req_if;
  riscv_core_pkg::addr_t addr;
  // Register value, not yet placed in its lane.
  riscv_core_pkg::word_t wdata;
  logic [2:0] size;
  logic bus_enable;
  logic write_enable;
  // Aligned and extended.
  riscv_core_pkg::word_t rdata;

  modport ctrl (
    output addr, wdata, size, bus_enable, write_enable,
    input rdata
  );

  modport lsu (
    input addr, wdata, size, bus_enable, write_enable,
    output rdata
  );
endinterface

/* src/ram_bus_if.sv */
////////////////////
// No back-pressure. The RAM always answers in one cycle.
////////////////////
interface ram_bus_if;
  logic [riscv_core_pkg::addr_width-3:0] word_addr;
  riscv_core_pkg::word_t wdata;
  // Active high, one bit per byte lane.
  logic [3:0] byte_enable;
  logic bus_enable;
  logic write_enable;
  riscv_core_pkg::word_t rdata;

  modport lsu (
    output word_addr, wdata, byte_enable, bus_enable, write_enable,
    input rdata
  );

  modport mem (
    input word_addr, wdata, byte_enable, bus_enable, write_enable,
    output rdata
  );
endinterface

/* src/register_file.sv */
////////////////////
// No reset. Registers hold X until first written.
////////////////////
module register_file (
  input  logic                  raw_clk,
  input  logic [4:0]            rs1_addr,
  input  logic [4:0]            rs2_addr,
  input  logic [4:0]            rd_addr,
  input  logic                  rd_write,
  input  riscv_core_pkg::word_t rd_data,
  output riscv_core_pkg::word_t rs1_data,
  output riscv_core_pkg::word_t rs2_data,
  output riscv_core_pkg::word_t x6_data
);

  riscv_core_pkg::word_t regs [32];

  always_ff @(posedge raw_clk) begin
    if (rd_write)
      regs[rd_addr] <= rd_data;
  end

  // x0 reads as zero whatever the array holds.
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  // Debug view.
  assign x6_data = regs[6];

endmodule

/* src/alu.sv */
////////////////////
// Purely combinational. Shift amount is the low five bits of b.
////////////////////
module alu (
  input  logic [2:0]            funct3,
  input  logic                  alt,
  input  logic                  use_alt,
  input  riscv_core_pkg::word_t a,
  input  riscv_core_pkg::word_t b,
  output riscv_core_pkg::word_t result,
  output logic                  branch_taken
);

  logic [$clog2(riscv_isa_pkg::xlen)-1:0] shamt;
  logic alt_sel;

  assign shamt = b[$clog2(riscv_isa_pkg::xlen)-1:0];
  // Ignored for addi, whose immediate can carry bit 30.
  assign alt_sel = alt && use_alt;

  always_comb begin
    case (funct3)
      riscv_isa_pkg::alu_add:  result = alt_sel ? a - b : a + b;
      riscv_isa_pkg::alu_sll:  result = a << shamt;
      riscv_isa_pkg::alu_slt:  result = riscv_core_pkg::word_t'($signed(a) < $signed(b));
      riscv_isa_pkg::alu_sltu: result = riscv_core_pkg::word_t'(a < b);
      riscv_isa_pkg::alu_xor:  result = a ^ b;
      riscv_isa_pkg::alu_srl:
        begin
          if (alt_sel)
            result = $signed(a) >>> shamt;
          else
            result = a >> shamt;
        end
      riscv_isa_pkg::alu_or:   result = a | b;
      default:                 result = a & b;
    endcase
  end

  // Branch compare on the same operands.
  always_comb begin
    case (funct3)
      riscv_isa_pkg::br_beq:  branch_taken = (a == b);
      riscv_isa_pkg::br_bne:  branch_taken = (a != b);
      riscv_isa_pkg::br_blt:  branch_taken = ($signed(a) < $signed(b));
      riscv_isa_pkg::br_bge:  branch_taken = ($signed(a) >= $signed(b));
      riscv_isa_pkg::br_bltu: branch_taken = (a < b);
      riscv_isa_pkg::br_bgeu: branch_taken = (a >= b);
      default:                branch_taken = 1'b0;
    endcase
  end

endmodule

/* src/load_store_unit.sv */
////////////////////
// Halfwords must not cross a word. Load data is valid one cycle after the request.
////////////////////
module load_store_unit (
  input logic     raw_clk,
  data_req_if.lsu req,
  ram_bus_if.lsu  ram
);

  logic [1:0]  offset_q;
  logic [2:0]  size_q;
  logic [7:0]  lane_byte;
  logic [15:0] lane_half;

  assign ram.word_addr = req.addr[riscv_core_pkg::addr_width-1:2];
  assign ram.bus_enable = req.bus_enable;
  assign ram.write_enable = req.write_enable;

  // Store value copied into every lane. Byte enables pick the one written.
  always_comb begin
    case (req.size)
      riscv_isa_pkg::size_byte:
        begin
          ram.wdata = {4{req.wdata[7:0]}};
          ram.byte_enable = 4'b0001 << req.addr[1:0];
        end
      riscv_isa_pkg::size_half:
        begin
          ram.wdata = {2{req.wdata[15:0]}};
          ram.byte_enable = req.addr[1] ? 4'b1100 : 4'b0011;
        end
      default:
        begin
          ram.wdata = req.wdata;
          ram.byte_enable = 4'b1111;
        end
    endcase
  end

  // Lane and size of a read, kept for the data cycle.
  always_ff @(posedge raw_clk) begin
    if (req.bus_enable && !req.write_enable)
    begin
      offset_q <= req.addr[1:0];
      size_q <= req.size;
    end
  end

  assign lane_byte = ram.rdata[8*offset_q +: 8];
  assign lane_half = offset_q[1] ? ram.rdata[31:16] : ram.rdata[15:0];

  always_comb begin
    case (size_q)
      riscv_isa_pkg::size_byte:   req.rdata = {{24{lane_byte[7]}}, lane_byte};
      riscv_isa_pkg::size_byte_u: req.rdata = {24'b0, lane_byte};
      riscv_isa_pkg::size_half:   req.rdata = {{16{lane_half[15]}}, lane_half};
      riscv_isa_pkg::size_half_u: req.rdata = {16'b0, lane_half};
      // Words and instruction fetches pass unchanged.
      default:                    req.rdata = ram.rdata;
    endcase
  end

endmodule

/* src/program_ram.sv */
////////////////////
// Addresses wrap at the RAM depth. The load port wins over the core port.
////////////////////
module program_ram (
  input logic                  raw_clk,
  ram_bus_if.mem               mem,
  input logic                  load_enable,
  input riscv_core_pkg::addr_t load_address,
  input riscv_core_pkg::word_t load_data
);

  riscv_core_pkg::word_t words [riscv_core_pkg::ram_words];
  logic [riscv_core_pkg::ram_index_width-1:0] core_index;
  logic [riscv_core_pkg::ram_index_width-1:0] load_index;

  assign core_index = mem.word_addr[riscv_core_pkg::ram_index_width-1:0];
  assign load_index = load_address[riscv_core_pkg::ram_index_width+1:2];

  always_ff @(posedge raw_clk) begin
    if (load_enable)
      words[load_index] <= load_data;
    else if (mem.bus_enable && mem.write_enable)
    begin
      for (int lane = 0; lane < 4; lane++)
      begin
        if (mem.byte_enable[lane])
          words[core_index][8*lane +: 8] <= mem.wdata[8*lane +: 8];
      end
    end

    // Old data on a write cycle.
    if (mem.bus_enable)
      mem.rdata <= words[core_index];
  end

endmodule

/* src/core_control.sv */
////////////////////
// One instruction at a time. Misaligned accesses are not trapped.
////////////////////
module core_control (
  input  logic                  raw_clk,
  input  logic                  button_reset,
  input  logic                  button_halt,
  data_req_if.ctrl              bus,
  output logic                  halted,
  output logic                  error,
  output riscv_core_pkg::addr_t pc,
  output riscv_core_pkg::word_t reg6_value
);

  riscv_core_pkg::state_e state;
  riscv_core_pkg::addr_t pc_current;
  riscv_isa_pkg::instr_t ir;
  riscv_core_pkg::word_t operand;
  riscv_core_pkg::word_t result;

  riscv_core_pkg::word_t imm_i;
  riscv_core_pkg::word_t imm_s;
  riscv_core_pkg::word_t imm_b;
  riscv_core_pkg::word_t imm_u;
  riscv_core_pkg::word_t imm_j;
  riscv_core_pkg::word_t rs1_data;
  riscv_core_pkg::word_t rs2_data;
  riscv_core_pkg::word_t alu_result;
  riscv_core_pkg::word_t ea;
  riscv_core_pkg::word_t rd_data;
  riscv_core_pkg::addr_t jal_target;
  riscv_core_pkg::addr_t branch_target;
  logic branch_taken;
  logic writeback;
  logic rd_write;

  // Immediates, one per format view.
  assign imm_i = {{20{ir.i.imm[11]}}, ir.i.imm};
  assign imm_s = {{20{ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
  assign imm_b = {{19{ir.b.imm_12}}, ir.b.imm_12, ir.b.imm_11, ir.b.imm_10_5,
                  ir.b.imm_4_1, 1'b0};
  assign imm_u = {ir.u.imm, 12'b0};
  assign imm_j = {{11{ir.j.imm_20}}, ir.j.imm_20, ir.j.imm_19_12, ir.j.imm_11,
                  ir.j.imm_10_1, 1'b0};

  // Effective address for loads, stores and jalr.
  assign ea = rs1_data + ((ir.r.opcode == riscv_isa_pkg::op_store) ? imm_s : imm_i);
  assign jal_target = pc_current + riscv_core_pkg::addr_t'(imm_j);
  assign branch_target = pc_current + riscv_core_pkg::addr_t'(imm_b);

  // Fetch is a word read, stores go out from the latched address.
  assign bus.bus_enable = (state == riscv_core_pkg::st_fetch_0)
                       || (state == riscv_core_pkg::st_store_0)
                       || (state == riscv_core_pkg::st_decode
                           && ir.r.opcode == riscv_isa_pkg::op_load);
  assign bus.write_enable = (state == riscv_core_pkg::st_store_0);
  assign bus.addr = (state == riscv_core_pkg::st_fetch_0) ? pc
                  : (state == riscv_core_pkg::st_store_0) ? riscv_core_pkg::addr_t'(result)
                  : riscv_core_pkg::addr_t'(ea);
  assign bus.size = (state == riscv_core_pkg::st_fetch_0) ? riscv_isa_pkg::size_word
                  : ir.i.funct3;
  assign bus.wdata = operand;

  assign halted = (state == riscv_core_pkg::st_halted);
  assign error = (state == riscv_core_pkg::st_error);

  always_comb begin
    rd_data = result;
    writeback = 1'b0;
    case (state)
      riscv_core_pkg::st_decode:
        begin
          writeback = 1'b1;
          case (ir.r.opcode)
            riscv_isa_pkg::op_lui:   rd_data = imm_u;
            riscv_isa_pkg::op_auipc: rd_data = riscv_core_pkg::word_t'(pc_current) + imm_u;
            // Link value, pc is already past this instruction.
            riscv_isa_pkg::op_jal,
            riscv_isa_pkg::op_jalr:  rd_data = riscv_core_pkg::word_t'(pc);
            default:                 writeback = 1'b0;
          endcase
        end
      riscv_core_pkg::st_alu_wb: writeback = 1'b1;
      riscv_core_pkg::st_load_wait:
        begin
          rd_data = bus.rdata;
          writeback = 1'b1;
        end
      default: writeback = 1'b0;
    endcase
  end

  // x0 is never written.
  assign rd_write = writeback && (ir.r.rd != '0);

  always_ff @(posedge raw_clk) begin
    if (!button_reset)
    begin
      state <= riscv_core_pkg::st_reset;
      pc <= riscv_core_pkg::reset_pc;
    end
    else if (!button_halt)
      state <= riscv_core_pkg::st_halted;
    else
    begin
      case (state)
        riscv_core_pkg::st_reset: state <= riscv_core_pkg::st_fetch_0;
        riscv_core_pkg::st_fetch_0:
          begin
            pc_current <= pc;
            pc <= pc + riscv_core_pkg::addr_t'(4);
            state <= riscv_core_pkg::st_fetch_1;
          end
        riscv_core_pkg::st_fetch_1:
          begin
            ir <= bus.rdata;
            state <= riscv_core_pkg::st_decode;
          end
        riscv_core_pkg::st_decode:
          begin
            operand <= rs2_data;
            state <= riscv_core_pkg::st_fetch_0;
            case (ir.r.opcode)
              riscv_isa_pkg::op_lui, riscv_isa_pkg::op_auipc: ;
              riscv_isa_pkg::op_jal: pc <= jal_target;
              riscv_isa_pkg::op_jalr: pc <= {ea[riscv_core_pkg::addr_width-1:2], 2'b00};
              riscv_isa_pkg::op_branch: state <= riscv_core_pkg::st_branch;
              riscv_isa_pkg::op_load: state <= riscv_core_pkg::st_load_wait;
              riscv_isa_pkg::op_store:
                begin
                  result <= ea;
                  state <= riscv_core_pkg::st_store_0;
                end
              riscv_isa_pkg::op_op_imm:
                begin
                  result <= alu_result;
                  state <= riscv_core_pkg::st_alu_wb;
                end
              riscv_isa_pkg::op_op: state <= riscv_core_pkg::st_alu_rr;
              riscv_isa_pkg::op_system: state <= riscv_core_pkg::st_halted;
              default: state <= riscv_core_pkg::st_error;
            endcase
          end
        riscv_core_pkg::st_alu_rr:
          begin
            result <= alu_result;
            state <= riscv_core_pkg::st_alu_wb;
          end
        riscv_core_pkg::st_branch:
          begin
            if (branch_taken)
              pc <= branch_target;
            state <= riscv_core_pkg::st_fetch_0;
          end
        riscv_core_pkg::st_store_0: state <= riscv_core_pkg::st_store_1;
        riscv_core_pkg::st_alu_wb,
        riscv_core_pkg::st_load_wait,
        riscv_core_pkg::st_store_1: state <= riscv_core_pkg::st_fetch_0;
        // halted and error are sticky
        default: state <= state;
      endcase
    end
  end

  register_file register_file_i (
    .raw_clk  (raw_clk),
    .rs1_addr (ir.r.rs1),
    .rs2_addr (ir.r.rs2),
    .rd_addr  (ir.r.rd),
    .rd_write (rd_write),
    .rd_data  (rd_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .x6_data  (reg6_value)
  );

  // Immediate operand only while decoding op_imm.
  alu alu_i (
    .funct3       (ir.r.funct3),
    .alt          (ir.r.funct7 == riscv_isa_pkg::alt_funct7),
    .use_alt      ((ir.r.opcode == riscv_isa_pkg::op_op)
                   || (ir.r.funct3 == riscv_isa_pkg::alu_sll)
                   || (ir.r.funct3 == riscv_isa_pkg::alu_srl)),
    .a            (rs1_data),
    .b            ((state == riscv_core_pkg::st_decode) ? imm_i : operand),
    .result       (alu_result),
    .branch_taken (branch_taken)
  );

endmodule

/* src/riscv_soc.sv */
////////////////////
// Load programs only while button_reset is held low.
// load_address is a byte address; the low two bits are ignored.
////////////////////
module riscv_soc (
  input  logic                  raw_clk,
  input  logic                  button_reset,
  input  logic                  button_halt,
  input  logic                  load_enable,
  input  riscv_core_pkg::addr_t load_address,
  input  riscv_core_pkg::word_t load_data,
  output logic                  halted,
  output logic                  error,
  output riscv_core_pkg::addr_t pc,
  output riscv_core_pkg::word_t reg6_value
);

  data_req_if data_req ();
  ram_bus_if  ram_bus ();

  program_ram program_ram_i (
    .raw_clk      (raw_clk),
    .mem          (ram_bus.mem),
    .load_enable  (load_enable),
    .load_address (load_address),
    .load_data    (load_data)
  );

  // Lane placement between core and RAM.
  load_store_unit load_store_unit_i (
    .raw_clk (raw_clk),
    .req     (data_req.lsu),
    .ram     (ram_bus.lsu)
  );

  core_control core_control_i (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .button_halt  (button_halt),
    .bus          (data_req.ctrl),
    .halted       (halted),
    .error        (error),
    .pc           (pc),
    .reg6_value   (reg6_value)
  );

endmodule

/* verif/riscv_soc_checker.sv */
////////////////////
// Sampled on raw_clk. Reset is synchronous, so its effect shows one edge later.
////////////////////
module riscv_soc_checker (
  input logic                  raw_clk,
  input logic                  button_reset,
  input logic                  halted,
  input logic                  error,
  input riscv_core_pkg::addr_t pc,
  input riscv_core_pkg::word_t reg6_value,
  input riscv_core_pkg::word_t expected_reg6
);

  int failures = 0;

  exclusive_stop: assert property (@(posedge raw_clk) disable iff (!button_reset)
    !(halted && error))
  else
  begin
    failures++;
    $error("ERROR halted=%h error=%h, both high together", halted, error);
  end

  reset_clears_stop: assert property (@(posedge raw_clk)
    !button_reset |=> !halted && !error)
  else
  begin
    failures++;
    $error("halted or error still high after a reset edge");
  end

  // Only reset leaves the halted state.
  halted_sticky: assert property (@(posedge raw_clk) disable iff (!button_reset)
    halted |=> halted)
  else
  begin
    failures++;
    $error("halted dropped without a reset");
  end

  reg6_at_halt: assert property (@(posedge raw_clk) disable iff (!button_reset)
    $rose(halted) |-> reg6_value == expected_reg6)
  else
  begin
    failures++;
    $error("ERROR reg6_value=%h expected %h", reg6_value, expected_reg6);
  end

  pc_aligned: assert property (@(posedge raw_clk) disable iff (!button_reset)
    pc[1:0] == 2'b00)
  else
  begin
    failures++;
    $error("ERROR pc=%h low bits not clear", pc);
  end

endmodule

/* verif/riscv_soc_tb.sv */
////////////////////
// Six hand-assembled programs, each loaded while reset is held low.
// Each program ends in ecall, an unknown opcode, or the halt button.
////////////////////
module riscv_soc_tb;

  localparam int num_programs = 6;
  localparam int cycles_per_program = 400;
  localparam riscv_core_pkg::word_t ecall_word = 32'h0000_0073;
  // custom-0 opcode, outside the supported subset.
  localparam riscv_core_pkg::word_t unknown_word = 32'h0000_000b;

  logic raw_clk = 1'b0;
  logic button_reset;
  logic button_halt;
  logic load_enable;
  riscv_core_pkg::addr_t load_address;
  riscv_core_pkg::word_t load_data;
  logic halted;
  logic error;
  riscv_core_pkg::addr_t pc;
  riscv_core_pkg::word_t reg6_value;

  riscv_core_pkg::word_t expected_reg6;
  riscv_core_pkg::word_t program_words[$];
  int seed = 99152;
  int tb_failures = 0;

  always #10 raw_clk = ~raw_clk;

  riscv_soc dut_i (
    .raw_clk      (raw_clk),
    .button_reset (button_reset),
    .button_halt  (button_halt),
    .load_enable  (load_enable),
    .load_address (load_address),
    .load_data    (load_data),
    .halted       (halted),
    .error        (error),
    .pc           (pc),
    .reg6_value   (reg6_value)
  );

  bind riscv_soc riscv_soc_checker checker_i (
    .raw_clk       (raw_clk),
    .button_reset  (button_reset),
    .halted        (halted),
    .error         (error),
    .pc            (pc),
    .reg6_value    (reg6_value),
    .expected_reg6 (riscv_soc_tb.expected_reg6)
  );

  // Instruction encoders, fields in instruction order.
  function automatic riscv_core_pkg::word_t encode_r(logic [6:0] funct7, logic [4:0] rs2,
      logic [4:0] rs1, logic [2:0] funct3, logic [4:0] rd);
    return {funct7, rs2, rs1, funct3, rd, riscv_isa_pkg::op_op};
  endfunction

  function automatic riscv_core_pkg::word_t encode_i(logic [11:0] imm, logic [4:0] rs1,
      logic [2:0] funct3, logic [4:0] rd, riscv_isa_pkg::opcode_e opcode);
    return {imm, rs1, funct3, rd, opcode};
  endfunction

  function automatic riscv_core_pkg::word_t encode_s(logic [11:0] imm, logic [4:0] rs2,
      logic [4:0] rs1, logic [2:0] funct3);
    return {imm[11:5], rs2, rs1, funct3, imm[4:0], riscv_isa_pkg::op_store};
  endfunction

  function automatic riscv_core_pkg::word_t encode_b(logic [12:0] offset, logic [4:0] rs2,
      logic [4:0] rs1, logic [2:0] funct3);
    return {offset[12], offset[10:5], rs2, rs1, funct3, offset[4:1], offset[11],
            riscv_isa_pkg::op_branch};
  endfunction

  function automatic riscv_core_pkg::word_t encode_u(logic [19:0] imm, logic [4:0] rd,
      riscv_isa_pkg::opcode_e opcode);
    return {imm, rd, opcode};
  endfunction

  function automatic riscv_core_pkg::word_t encode_j(logic [20:0] offset, logic [4:0] rd);
    return {offset[20], offset[10:1], offset[11], offset[19:12], rd, riscv_isa_pkg::op_jal};
  endfunction

  task automatic push_addi(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
    program_words.push_back(encode_i(imm, rs1, riscv_isa_pkg::alu_add, rd,
                                     riscv_isa_pkg::op_op_imm));
  endtask

  task automatic push_rr(logic [2:0] funct3, logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
    program_words.push_back(encode_r(7'b0, rs2, rs1, funct3, rd));
  endtask

  task automatic load_const(logic [4:0] rd, riscv_core_pkg::word_t value);
    riscv_core_pkg::word_t upper;
    // The addi immediate is sign extended, so round the upper part.
    upper = value + 32'h0000_0800;
    program_words.push_back(encode_u(upper[31:12], rd, riscv_isa_pkg::op_lui));
    push_addi(rd, rd, value[11:0]);
  endtask

  // x3 = x1 op x2, then x6 ^= x3.
  task automatic fold_op(logic [6:0] funct7, logic [2:0] funct3);
    program_words.push_back(encode_r(funct7, 5'd2, 5'd1, funct3, 5'd3));
    push_rr(riscv_isa_pkg::alu_xor, 5'd6, 5'd6, 5'd3);
  endtask

  // Taken branch skips the addi, so a bit in x6 marks a not-taken branch.
  task automatic branch_probe(logic [2:0] funct3, logic [11:0] bit_value);
    program_words.push_back(encode_b(13'd8, 5'd2, 5'd1, funct3));
    push_addi(5'd6, 5'd6, bit_value);
  endtask

  task automatic push_load(logic [4:0] rd, logic [11:0] offset, logic [2:0] size);
    program_words.push_back(encode_i(offset, 5'd5, size, rd, riscv_isa_pkg::op_load));
  endtask

  task automatic check_level(string name, logic actual, logic expected);
    assert (actual == expected)
    else
    begin
      tb_failures++;
      $display("ERROR %s=%h expected %h", name, actual, expected);
    end
  endtask

  // Loads the queued program under reset, then lets the core run.
  task automatic start_program(riscv_core_pkg::word_t expected);
    int reset_cycles;
    reset_cycles = (program_words.size() > 10) ? program_words.size() : 10;
    @(posedge raw_clk);
    button_reset <= 1'b0;
    expected_reg6 <= expected;
    for (int i = 0; i < reset_cycles; i++)
    begin
      load_enable <= (i < program_words.size());
      load_address <= riscv_core_pkg::addr_t'(4 * i);
      load_data <= (i < program_words.size()) ? program_words[i] : '0;
      @(posedge raw_clk);
    end
    load_enable <= 1'b0;
    button_reset <= 1'b1;
    program_words.delete();
  endtask

  task automatic finish_program(logic expect_error);
    wait (halted || error);
    @(negedge raw_clk);
    check_level("halted", halted, !expect_error);
    check_level("error", error, expect_error);
  endtask

  task automatic alu_program();
    riscv_core_pkg::word_t a;
    riscv_core_pkg::word_t b;
    riscv_core_pkg::word_t e;
    riscv_core_pkg::word_t t;
    a = $random(seed);
    b = $random(seed);
    load_const(5'd1, a);
    load_const(5'd2, b);
    push_rr(riscv_isa_pkg::alu_add, 5'd6, 5'd1, 5'd2);
    fold_op(riscv_isa_pkg::alt_funct7, riscv_isa_pkg::alu_add);
    fold_op(7'b0, riscv_isa_pkg::alu_xor);
    fold_op(7'b0, riscv_isa_pkg::alu_or);
    fold_op(7'b0, riscv_isa_pkg::alu_and);
    fold_op(7'b0, riscv_isa_pkg::alu_sll);
    fold_op(7'b0, riscv_isa_pkg::alu_srl);
    fold_op(riscv_isa_pkg::alt_funct7, riscv_isa_pkg::alu_srl);
    fold_op(7'b0, riscv_isa_pkg::alu_slt);
    fold_op(7'b0, riscv_isa_pkg::alu_sltu);
    // srai x3, x1, 7
    program_words.push_back(encode_i({riscv_isa_pkg::alt_funct7, 5'd7}, 5'd1,
                                     riscv_isa_pkg::alu_srl, 5'd3, riscv_isa_pkg::op_op_imm));
    push_rr(riscv_isa_pkg::alu_xor, 5'd6, 5'd6, 5'd3);
    program_words.push_back(ecall_word);
    e = a + b;
    e = e ^ (a - b);
    e = e ^ (a ^ b);
    e = e ^ (a | b);
    e = e ^ (a & b);
    e = e ^ (a << b[4:0]);
    e = e ^ (a >> b[4:0]);
    t = $signed(a) >>> b[4:0];
    e = e ^ t;
    e = e ^ {31'b0, $signed(a) < $signed(b)};
    e = e ^ {31'b0, a < b};
    t = $signed(a) >>> 7;
    e = e ^ t;
    start_program(e);
    finish_program(1'b0);
  endtask

  task automatic memory_program();
    riscv_core_pkg::word_t v1;
    riscv_core_pkg::word_t v2;
    riscv_core_pkg::word_t m;
    riscv_core_pkg::word_t e;
    v1 = $random(seed);
    v2 = $random(seed);
    load_const(5'd1, v1);
    load_const(5'd2, v2);
    push_addi(5'd5, 5'd0, 12'h200);
    program_words.push_back(encode_s(12'd0, 5'd1, 5'd5, riscv_isa_pkg::size_word));
    program_words.push_back(encode_s(12'd1, 5'd2, 5'd5, riscv_isa_pkg::size_byte));
    program_words.push_back(encode_s(12'd2, 5'd2, 5'd5, riscv_isa_pkg::size_half));
    push_load(5'd3, 12'd1, riscv_isa_pkg::size_byte);
    push_load(5'd4, 12'd3, riscv_isa_pkg::size_byte_u);
    push_load(5'd7, 12'd2, riscv_isa_pkg::size_half);
    push_load(5'd8, 12'd0, riscv_isa_pkg::size_half_u);
    push_load(5'd9, 12'd0, riscv_isa_pkg::size_word);
    push_rr(riscv_isa_pkg::alu_add, 5'd6, 5'd3, 5'd4);
    push_rr(riscv_isa_pkg::alu_add, 5'd6, 5'd6, 5'd7);
    push_rr(riscv_isa_pkg::alu_add, 5'd6, 5'd6, 5'd8);
    push_rr(riscv_isa_pkg::alu_add, 5'd6, 5'd6, 5'd9);
    program_words.push_back(ecall_word);
    // Little endian word after the three stores.
    m = {v2[15:0], v2[7:0], v1[7:0]};
    e = {{24{m[15]}}, m[15:8]};
    e = e + {24'b0, m[31:24]};
    e = e + {{16{m[31]}}, m[31:16]};
    e = e + {16'b0, m[15:0]};
    e = e + m;
    start_program(e);
    finish_program(1'b0);
  endtask

  task automatic branch_program();
    riscv_core_pkg::word_t n;
    riscv_core_pkg::word_t a;
    riscv_core_pkg::word_t b;
    riscv_core_pkg::word_t e;
    n = 32'd1 + ($unsigned($random(seed)) % 32'd15);
    a = $random(seed);
    b = $random(seed);
    a[31] = 1'b1;
    b[31] = 1'b0;
    push_addi(5'd6, 5'd0, n[11:0]);
    push_addi(5'd7, 5'd0, 12'd0);
    push_addi(5'd6, 5'd6, 12'hfff);
    push_addi(5'd7, 5'd7, 12'd1);
    program_words.push_back(encode_b(-13'sd8, 5'd0, 5'd6, riscv_isa_pkg::br_bne));
    push_rr(riscv_isa_pkg::alu_xor, 5'd6, 5'd6, 5'd7);
    load_const(5'd1, a);
    load_const(5'd2, b);
    branch_probe(riscv_isa_pkg::br_blt, 12'h010);
    branch_probe(riscv_isa_pkg::br_bge, 12'h020);
    branch_probe(riscv_isa_pkg::br_bltu, 12'h040);
    branch_probe(riscv_isa_pkg::br_bgeu, 12'h080);
    program_words.push_back(ecall_word);
    // The loop leaves x6 at zero and the taken count n in x7.
    e = n;
    if (!($signed(a) < $signed(b)))
      e = e + 32'h10;
    if (!($signed(a) >= $signed(b)))
      e = e + 32'h20;
    if (!(a < b))
      e = e + 32'h40;
    if (!(a >= b))
      e = e + 32'h80;
    start_program(e);
    finish_program(1'b0);
  endtask

  task automatic call_program();
    riscv_core_pkg::word_t c;
    riscv_core_pkg::word_t d;
    riscv_core_pkg::word_t e;
    c = $random(seed);
    d = $random(seed);
    d[31:11] = '0;
    load_const(5'd6, c);
    program_words.push_back(encode_j(21'h28, 5'd1));
    push_rr(riscv_isa_pkg::alu_xor, 5'd6, 5'd6, 5'd1);
    program_words.push_back(encode_u(20'd0, 5'd5, riscv_isa_pkg::op_auipc));
    program_words.push_back(encode_i(12'h020, 5'd5, 3'b000, 5'd1, riscv_isa_pkg::op_jalr));
    push_rr(riscv_isa_pkg::alu_xor, 5'd6, 5'd6, 5'd1);
    program_words.push_back(encode_u(20'd0, 5'd5, riscv_isa_pkg::op_lui));
    // Odd target, bit 0 is cleared by jalr.
    program_words.push_back(encode_i(12'h031, 5'd5, 3'b000, 5'd1, riscv_isa_pkg::op_jalr));
    push_rr(riscv_isa_pkg::alu_xor, 5'd6, 5'd6, 5'd1);
    program_words.push_back(ecall_word);
    program_words.push_back(ecall_word);
    // Subroutine at 0x30.
    push_addi(5'd6, 5'd6, d[11:0]);
    program_words.push_back(encode_i(12'h000, 5'd1, 3'b000, 5'd0, riscv_isa_pkg::op_jalr));
    // Links are the call address plus four: 0x0c, 0x18, 0x24.
    e = c;
    e = (e + d) ^ 32'h0c;
    e = (e + d) ^ 32'h18;
    e = (e + d) ^ 32'h24;
    start_program(e);
    finish_program(1'b0);
  endtask

  task automatic unknown_opcode_program();
    push_addi(5'd6, 5'd0, 12'd5);
    program_words.push_back(unknown_word);
    program_words.push_back(ecall_word);
    start_program(32'd5);
    finish_program(1'b1);
    repeat (3) @(negedge raw_clk);
    check_level("error", error, 1'b1);
  endtask

  task automatic halt_button_program();
    riscv_core_pkg::word_t k;
    k = $random(seed);
    k[31:11] = '0;
    push_addi(5'd6, 5'd0, k[11:0]);
    push_addi(5'd7, 5'd0, 12'd0);
    push_addi(5'd7, 5'd7, 12'd1);
    program_words.push_back(encode_j(-21'sd4, 5'd0));
    start_program(k);
    // Let the loop spin for a while.
    repeat (40) @(posedge raw_clk);
    button_halt <= 1'b0;
    @(posedge raw_clk);
    button_halt <= 1'b1;
    finish_program(1'b0);
    repeat (2) @(posedge raw_clk);
  endtask

  initial
  begin
    int checker_failures;
    button_reset = 1'b0;
    button_halt = 1'b1;
    load_enable = 1'b0;
    load_address = '0;
    load_data = '0;
    expected_reg6 = '0;
    alu_program();
    memory_program();
    branch_program();
    call_program();
    unknown_opcode_program();
    halt_button_program();
    checker_failures = dut_i.checker_i.failures;
    $display("Checker assertion failures: %0d, testbench assertion failures: %0d",
             checker_failures, tb_failures);
    if (checker_failures + tb_failures == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

  // Watchdog.
  initial
  begin
    #(num_programs * cycles_per_program * 20);
    $display("Timeout: the core did not stop within %0d cycles per program",
             cycles_per_program);
    $display("tests failed");
    $finish;
  end

endmodule

/* project.f */
src/riscv_isa_pkg.sv
src/riscv_core_pkg.sv
src/data_req_if.sv
src/ram_bus_if.sv
src/register_file.sv
src/alu.sv
src/load_store_unit.sv
src/program_ram.sv
src/core_control.sv
src/riscv_soc.sv
verif/riscv_soc_checker.sv
verif/riscv_soc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator, exits 1 when the log shows a failure.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module riscv_soc_tb \
  -f project.f -o riscv_soc_sim > build.log 2>&1 \
  || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/riscv_soc_sim +verilator+error+limit+1000 > sim.log 2>&1 \
  || echo "tests failed" >> sim.log
cat sim.log
grep -q "tests failed" sim.log && { echo "Simulation FAILED"; exit 1; } \
  || { echo "Simulation passed"; exit 0; }
